// File: logic/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Program counter width.
`define PC_WIDTH 32

// One instruction word.
`define INSTR_WIDTH 16

// Words in the instruction memory.
`define IMEM_DEPTH 256

// Entry point of the interrupt routine.
`define INT_VECTOR 0

`endif

// File: logic/isaPkg.sv
`default_nettype none

`include "cpu_config.svh"

package isaPkg;

    // A single instruction as it leaves the instruction memory.
    typedef logic [`INSTR_WIDTH-1:0] instrWord;

    // Bubble slot.
    localparam instrWord NOP_OP = 16'b0000_0000_0000_0000;

    // Pushes the ICU emits on interrupt entry.
    localparam instrWord PUSH_CCR_OP = 16'b0110_0000_0000_1010;
    localparam instrWord PUSH_PCL_OP = 16'b0110_0000_0000_1000;
    localparam instrWord PUSH_PCH_OP = 16'b0110_0000_0000_1001;

    // Interrupt entry sequence.
    // One state per injected slot, then the jump and the release wait.
    typedef enum logic [2:0] {
        idle,
        stall,
        pushCcr,
        pushPcl,
        pushPch,
        pcChange,
        waitRelease
    } icuState;

endpackage

`default_nettype wire

// File: logic/frontPkg.sv
`default_nettype none

`include "cpu_config.svh"

package frontPkg;

    import isaPkg::*;

    // Per-cycle order from the ICU to fetch.
    typedef struct packed {
        // Replace the fetched word with instr.
        logic     inject;
        instrWord instr;
        // Set only for the leading NOP slot.
        logic     stall;
        // Jump to the interrupt vector.
        logic     pcLoad;
    } icuCmd;

    // Registered hand-off to decode.
    typedef struct packed {
        logic                 valid;
        logic                 stall;
        logic                 injected;
        instrWord             instr;
        // Fetch address, or the return address for injected words.
        logic [`PC_WIDTH-1:0] pc;
    } decodeBundle;

    // Program loader write port.
    typedef struct packed {
        logic                          en;
        logic [$clog2(`IMEM_DEPTH)-1:0] addr;
        instrWord                      data;
    } imemWrite;

endpackage

`default_nettype wire

// File: logic/interruptControl.sv
`timescale 1ns/1ps
`default_nettype none

module interruptControl
    import isaPkg::*;
    import frontPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  intReq,
    input  logic  hold,
    output logic  intAck,
    output icuCmd cmd
);

    icuState state;

    // Sequence register and ack flag.
    // Nothing moves while decode holds the pipe.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state  <= idle;
            intAck <= 1'b0;
        end
        else if (!hold)
        begin
            case (state)
                idle:
                begin
                    // Ack left over from a short request drops here.
                    intAck <= 1'b0;
                    if (intReq && !intAck)
                    begin
                        state <= stall;
                    end
                end
                stall:
                begin
                    state <= pushCcr;
                end
                pushCcr:
                begin
                    state <= pushPcl;
                end
                pushPcl:
                begin
                    state <= pushPch;
                end
                pushPch:
                begin
                    state <= pcChange;
                end
                pcChange:
                begin
                    intAck <= 1'b1;
                    // Request already gone, so ack lives one cycle.
                    if (intReq)
                    begin
                        state <= waitRelease;
                    end
                    else
                    begin
                        state <= idle;
                    end
                end
                waitRelease:
                begin
                    if (!intReq)
                    begin
                        intAck <= 1'b0;
                        state  <= idle;
                    end
                end
                default:
                begin
                    state <= idle;
                end
            endcase
        end
    end

    // Command decode, purely from the state.
    always_comb
    begin
        cmd        = '0;
        cmd.instr  = NOP_OP;
        case (state)
            stall:
            begin
                cmd.inject = 1'b1;
                cmd.stall  = 1'b1;
            end
            pushCcr:
            begin
                cmd.inject = 1'b1;
                cmd.instr  = PUSH_CCR_OP;
            end
            pushPcl:
            begin
                cmd.inject = 1'b1;
                cmd.instr  = PUSH_PCL_OP;
            end
            pushPch:
            begin
                cmd.inject = 1'b1;
                cmd.instr  = PUSH_PCH_OP;
            end
            pcChange:
            begin
                cmd.pcLoad = 1'b1;
            end
            default:
            begin
                cmd.inject = 1'b0;
            end
        endcase
    end

    // Ack only rises as the jump completes.
    ackAfterJump: assert property (@(posedge clk) disable iff (rst)
        $rose(intAck) |-> $past(state) == pcChange);

    // The jump is reached only through the last push.
    jumpAfterPushes: assert property (@(posedge clk) disable iff (rst)
        cmd.pcLoad |-> $past(state) inside {pushPch, pcChange});

endmodule

`default_nettype wire

// File: logic/fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module fetchUnit
    import isaPkg::*;
    import frontPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        hold,
    input  icuCmd       cmd,
    input  imemWrite    load,
    output decodeBundle bundle
);

    localparam int AddrWidth = $clog2(`IMEM_DEPTH);

    logic [`PC_WIDTH-1:0] pc;
    logic [`PC_WIDTH-1:0] nextPc;
    instrWord             imem [`IMEM_DEPTH];
    instrWord             fetched;
    decodeBundle          nextBundle;

    // Loader port into program memory.
    always_ff @(posedge clk)
    begin
        if (load.en)
        begin
            imem[load.addr] <= load.data;
        end
    end

    // Asynchronous read at the current PC.
    assign fetched = imem[pc[AddrWidth-1:0]];

    // Next PC.
    always_comb
    begin
        if (cmd.pcLoad)
        begin
            nextPc = `PC_WIDTH'(`INT_VECTOR);
        end
        else if (cmd.inject)
        begin
            // Injected slots leave the fetch address alone.
            nextPc = pc;
        end
        else
        begin
            nextPc = pc + `PC_WIDTH'(1);
        end
    end

    // Pick what decode sees next.
    always_comb
    begin
        nextBundle.valid = 1'b1;
        nextBundle.pc    = pc;
        if (cmd.pcLoad)
        begin
            // Bubble while the PC moves to the vector.
            nextBundle.stall    = 1'b0;
            nextBundle.injected = 1'b1;
            nextBundle.instr    = NOP_OP;
        end
        else if (cmd.inject)
        begin
            nextBundle.stall    = cmd.stall;
            nextBundle.injected = 1'b1;
            nextBundle.instr    = cmd.instr;
        end
        else
        begin
            nextBundle.stall    = 1'b0;
            nextBundle.injected = 1'b0;
            nextBundle.instr    = fetched;
        end
    end

    // PC and decode register.
    // Both freeze under hold, in step with the ICU.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc              <= '0;
            bundle.valid    <= 1'b0;
            bundle.stall    <= 1'b0;
            bundle.injected <= 1'b0;
        end
        else if (!hold)
        begin
            pc     <= nextPc;
            bundle <= nextBundle;
        end
    end

    // Return address stays put across the push slots.
    pcHoldOnInject: assert property (@(posedge clk) disable iff (rst)
        cmd.inject |=> pc == $past(pc));

endmodule

`default_nettype wire

// File: logic/frontEnd.sv
`timescale 1ns/1ps
`default_nettype none

module frontEnd
    import frontPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // Four-phase interrupt handshake.
    input  logic        intReq,
    output logic        intAck,
    // Back-pressure from decode.
    input  logic        hold,
    // Program loader.
    input  imemWrite    load,
    // Registered output to decode.
    output decodeBundle bundle
);

    // ICU order to fetch, one per cycle.
    icuCmd cmd;

    interruptControl icu
    (
        .clk    (clk),
        .rst    (rst),
        .intReq (intReq),
        .hold   (hold),
        .intAck (intAck),
        .cmd    (cmd)
    );

    fetchUnit fetch
    (
        .clk    (clk),
        .rst    (rst),
        .hold   (hold),
        .cmd    (cmd),
        .load   (load),
        .bundle (bundle)
    );

endmodule

`default_nettype wire

// File: test/frontEndTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module frontEndTb
    import isaPkg::*;
    import frontPkg::*;
();

    localparam int ClkHalf     = 2;
    localparam int ResetCycles = 10;
    localparam int WaitLimit   = 40;
    localparam int AddrBits    = $clog2(`IMEM_DEPTH);

    logic        clk;
    logic        rst;
    logic        intReq;
    logic        intAck;
    logic        hold;
    imemWrite    load;
    decodeBundle bundle;

    // Program image as loaded, used for expected words.
    instrWord prog [`IMEM_DEPTH];

    // Next address the model expects fetch to read.
    logic [`PC_WIDTH-1:0] expPc;
    logic                 reqDrive;
    logic                 randomHold;
    logic                 heldEdge;
    int                   holdLeft;
    decodeBundle          lastBundle;
    logic                 lastAck;
    int                   errors;
    int                   testErrors;
    int                   testsRun;
    int                   seedVal;

    frontEnd dut0
    (
        .clk    (clk),
        .rst    (rst),
        .intReq (intReq),
        .intAck (intAck),
        .hold   (hold),
        .load   (load),
        .bundle (bundle)
    );

    always #ClkHalf clk = ~clk;

    task automatic reportFailure(input string name, input string text);
        $display("Error in %s: %s", name, text);
        testErrors++;
    endtask

    // Compare only the bundle bits that mask selects.
    task automatic compareBundle(input string name, input decodeBundle exp,
                                 input decodeBundle mask);
        if (((bundle ^ exp) & mask) !== '0)
        begin
            $display("Mismatch in %s: bundle expected %h, actual %h",
                     name, exp & mask, bundle & mask);
            testErrors++;
        end
    endtask

    task automatic verifyAck(input string name, input logic exp);
        if (intAck !== exp)
        begin
            $display("Mismatch in %s: intAck expected %b, actual %b", name, exp, intAck);
            testErrors++;
        end
    endtask

    function automatic decodeBundle fetchedAt(input logic [`PC_WIDTH-1:0] addr);
        decodeBundle b;
        b       = '0;
        b.valid = 1'b1;
        b.instr = prog[addr[AddrBits-1:0]];
        b.pc    = addr;
        return b;
    endfunction

    // Injected word, tagged with the return address.
    function automatic decodeBundle injectedSlot(input instrWord instr, input logic stall,
                                                 input logic [`PC_WIDTH-1:0] ret);
        decodeBundle b;
        b          = '0;
        b.valid    = 1'b1;
        b.stall    = stall;
        b.injected = 1'b1;
        b.instr    = instr;
        b.pc       = ret;
        return b;
    endfunction

    // One edge. Hold and intReq for the next edge go out here.
    task automatic cycle(input string name);
        logic nextHold;
        @(posedge clk);
        heldEdge = hold;
        if (randomHold && holdLeft == 0 && $urandom_range(2) == 0)
            holdLeft = 1 + $urandom_range(3);
        nextHold = randomHold && holdLeft > 0;
        if (nextHold)
            holdLeft--;
        hold   <= nextHold;
        intReq <= reqDrive;
        #1;
        if (heldEdge && (bundle !== lastBundle || intAck !== lastAck))
            reportFailure(name, "outputs changed on an edge with hold high");
        lastBundle = bundle;
        lastAck    = intAck;
    endtask

    // Run to the next edge that decode actually consumes.
    task automatic advance(input string name);
        int n;
        n = 0;
        cycle(name);
        while (heldEdge && n < WaitLimit)
        begin
            cycle(name);
            n++;
        end
        if (heldEdge)
            reportFailure(name, "hold never dropped");
    endtask

    task automatic consumeFetch(input string name);
        compareBundle(name, fetchedAt(expPc), '1);
        expPc++;
    endtask

    // Raise intReq and follow the whole entry sequence.
    task automatic runEntry(input string name, input logic dropReq);
        int                   n;
        logic [`PC_WIDTH-1:0] ret;
        decodeBundle          loose;
        n        = 0;
        reqDrive = 1'b1;
        advance(name);
        // Normal words until the ICU takes the request.
        while (!bundle.stall && n < WaitLimit)
        begin
            verifyAck(name, 1'b0);
            consumeFetch(name);
            advance(name);
            n++;
        end
        if (!bundle.stall)
        begin
            reportFailure(name, "stall slot never appeared");
            return;
        end
        ret = expPc;
        if (dropReq)
            reqDrive = 1'b0;
        compareBundle(name, injectedSlot(NOP_OP, 1'b1, ret), '1);
        verifyAck(name, 1'b0);
        advance(name);
        compareBundle(name, injectedSlot(PUSH_CCR_OP, 1'b0, ret), '1);
        verifyAck(name, 1'b0);
        advance(name);
        compareBundle(name, injectedSlot(PUSH_PCL_OP, 1'b0, ret), '1);
        verifyAck(name, 1'b0);
        advance(name);
        compareBundle(name, injectedSlot(PUSH_PCH_OP, 1'b0, ret), '1);
        verifyAck(name, 1'b0);
        // Bubble during the jump, flag and pc not fixed.
        loose          = '1;
        loose.injected = 1'b0;
        loose.pc       = '0;
        advance(name);
        compareBundle(name, injectedSlot(NOP_OP, 1'b0, ret), loose);
        verifyAck(name, 1'b1);
        advance(name);
        expPc = `PC_WIDTH'(`INT_VECTOR);
        consumeFetch(name);
        verifyAck(name, !dropReq);
    endtask

    // Drop intReq and wait for intAck to fall.
    task automatic releaseAck(input string name, input logic checkLatency);
        int n;
        n        = 0;
        reqDrive = 1'b0;
        do
        begin
            advance(name);
            consumeFetch(name);
            n++;
        end
        while (intAck && n < WaitLimit);
        if (intAck)
            reportFailure(name, "intAck stayed high after intReq dropped");
        else if (checkLatency && n != 2)
        begin
            $display("Mismatch in %s: edges to ack release expected 2, actual %0d", name, n);
            testErrors++;
        end
    endtask

    task automatic loadProgram();
        for (int i = 0; i < `IMEM_DEPTH; i++)
        begin
            @(posedge clk);
            load.en   <= 1'b1;
            load.addr <= AddrBits'(i);
            load.data <= prog[i];
        end
        @(posedge clk);
        load.en <= 1'b0;
    endtask

    task automatic closeTest(input string name);
        $display("%s: %0d errors", name, testErrors);
        errors     += testErrors;
        testErrors  = 0;
        testsRun++;
    endtask

    task automatic fetchInOrder();
        repeat (12)
        begin
            advance("fetch order");
            consumeFetch("fetch order");
            verifyAck("fetch order", 1'b0);
        end
        closeTest("fetch order");
    endtask

    task automatic longRequest();
        runEntry("long request", 1'b0);
        repeat (3)
        begin
            advance("long request");
            consumeFetch("long request");
            verifyAck("long request", 1'b1);
        end
        releaseAck("long request", 1'b1);
        closeTest("long request");
    endtask

    task automatic shortRequest();
        runEntry("short request", 1'b1);
        runEntry("short request again", 1'b1);
        closeTest("short request");
    endtask

    task automatic holdStretches();
        randomHold = 1'b1;
        runEntry("hold stretches", 1'b0);
        randomHold = 1'b0;
        holdLeft   = 0;
        releaseAck("hold stretches", 1'b0);
        closeTest("hold stretches");
    endtask

    initial
    begin
        seedVal    = $urandom(32'h1304_90a0);
        clk        = 1'b0;
        rst        = 1'b1;
        intReq     = 1'b0;
        hold       = 1'b1;
        load       = '0;
        reqDrive   = 1'b0;
        randomHold = 1'b0;
        holdLeft   = 0;
        errors     = 0;
        testErrors = 0;
        testsRun   = 0;
        for (int i = 0; i < `IMEM_DEPTH; i++)
            prog[i] = instrWord'($urandom);
        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b0;
        // Hold keeps pc at zero while the program goes in.
        loadProgram();
        #1;
        lastBundle = bundle;
        lastAck    = intAck;
        expPc      = '0;
        fetchInOrder();
        longRequest();
        shortRequest();
        holdStretches();
        $display("Tests run: %0d, errors: %0d", testsRun, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    // Watchdog for the whole run.
    initial
    begin
        #50000;
        $display("Simulation ran past its time limit");
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+logic
logic/isaPkg.sv
logic/frontPkg.sv
logic/interruptControl.sv
logic/fetchUnit.sv
logic/frontEnd.sv
test/frontEndTb.sv

// File: Makefile
TOOL     = verilator
TOP      = frontEndTb
FILELIST = list.f
FLAGS    = --timing --assert
OBJDIR   = obj_dir
LOG      = sim.log
PASS_MSG = Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The log search decides pass or fail.
sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
